// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -Wno-fatal -j 0
TOP       ?= armCoreTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)

run: compile
	./$(OBJDIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== build.f ====
verilog/armIsaPkg.sv
verilog/armPipePkg.sv
verilog/hazardIf.sv
verilog/alu.sv
verilog/hazardUnit.sv
verilog/controlUnit.sv
verilog/datapath.sv
verilog/armCore.sv
test/armCore_asserts.sv
test/armCoreTb.sv

// ==== test/armCoreTb.sv ====
/*
  Self-checking testbench for armCore. Runs a fixed program from a ROM
  table and compares every store against a table of expected stores.
  Memories are 256 words, indexed by address bits 9:2.
*/
`timescale 1ns/1ps

module armCoreTb
   import armIsaPkg::*;
   import armPipePkg::*;
();

   localparam int progLen = 40;
   localparam int numStores = 13;
   localparam int timeoutCycles = 3 * progLen + 20;

   logic                 clk, reset;
   logic [dataWidth-1:0] pc, instr, dataAdr, writeData, readData;
   logic                 memWrite;
   logic [dataWidth-1:0] rom [0:255];
   logic [dataWidth-1:0] ram [0:255];
   logic [dataWidth-1:0] progTable [0:progLen-1];
   logic [63:0]          expStores [0:numStores-1];  // {address, data}
   int                   storeIdx, checkErrors, otherErrors, cycles;

   armCore armCore_i (.clk, .reset, .pc, .instr, .memWrite, .dataAdr, .writeData, .readData);

   bind armCore armCore_asserts asserts_i (
      .clk, .reset, .stallF(hz.stallF), .stallD(hz.stallD), .memWrite,
      .branchTakenE(hz.branchTakenE), .pc, .instrD
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] dpImm(condE c, dpFunctE f, logic s,
                                         logic [3:0] rn, logic [3:0] rd, logic [7:0] imm);
      return {c, 2'b00, 1'b1, f, s, rn, rd, 4'h0, imm};
   endfunction

   function automatic logic [31:0] dpReg(condE c, dpFunctE f, logic s,
                                         logic [3:0] rn, logic [3:0] rd, logic [3:0] rm);
      return {c, 2'b00, 1'b0, f, s, rn, rd, 8'h00, rm};
   endfunction

   // Pre-indexed, offset added, no writeback
   function automatic logic [31:0] memOp(condE c, logic load, logic [3:0] rn,
                                         logic [3:0] rd, logic [11:0] off);
      return {c, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, off};
   endfunction

   // Offset counts from the branch address plus 8
   function automatic logic [31:0] branchTo(condE c, int from, int to);
      logic [23:0] off;
      off = 24'(to - (from + 2));
      return {c, 4'b1010, off};
   endfunction

   // Inputs follow the memories 2 ns after each rising edge
   always @(posedge clk) begin
      #2;
      instr = rom[pc[9:2]];
      readData = ram[dataAdr[9:2]];
   end

   // Stores are taken mid-cycle where dataAdr and writeData are stable
   always @(negedge clk) begin
      if (!reset && memWrite) begin
         if (storeIdx >= numStores) begin
            otherErrors++;
            $display("Unexpected extra store to address %h", dataAdr);
         end else begin
            assert (dataAdr == expStores[storeIdx][63:32]) else begin
               checkErrors++;
               $display("CHECK FAILED dataAdr: got %h, expected %h (store %0d)",
                        dataAdr, expStores[storeIdx][63:32], storeIdx);
            end
            assert (writeData == expStores[storeIdx][31:0]) else begin
               checkErrors++;
               $display("CHECK FAILED writeData: got %h, expected %h (store %0d)",
                        writeData, expStores[storeIdx][31:0], storeIdx);
            end
            storeIdx++;
         end
         ram[dataAdr[9:2]] = writeData;
      end
   end

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      instr = '0;
      readData = '0;
      storeIdx = 0;
      checkErrors = 0;
      otherErrors = 0;
      cycles = 0;

      progTable[0]  = dpImm(condAl, fnAnd, 0, 4'd0, 4'd0, 8'h00);   // r0 = 0
      progTable[1]  = dpImm(condAl, fnAdd, 0, 4'd0, 4'd1, 8'h64);   // r1 = 0x64
      progTable[2]  = dpImm(condAl, fnSub, 0, 4'd1, 4'd2, 8'h07);   // r2 = 0x5d
      progTable[3]  = dpImm(condAl, fnAnd, 0, 4'd1, 4'd3, 8'h3c);   // r3 = 0x24
      progTable[4]  = dpImm(condAl, fnOrr, 0, 4'd1, 4'd4, 8'h0b);   // r4 = 0x6f
      progTable[5]  = memOp(condAl, 0, 4'd0, 4'd1, 12'h100);
      progTable[6]  = memOp(condAl, 0, 4'd0, 4'd2, 12'h104);
      progTable[7]  = memOp(condAl, 0, 4'd0, 4'd3, 12'h108);
      progTable[8]  = memOp(condAl, 0, 4'd0, 4'd4, 12'h10c);
      progTable[9]  = dpReg(condAl, fnAdd, 0, 4'd1, 4'd5, 4'd2);    // r5 = 0xc1
      progTable[10] = dpReg(condAl, fnSub, 0, 4'd5, 4'd6, 4'd1);    // r6 = 0x5d
      progTable[11] = dpReg(condAl, fnAdd, 0, 4'd5, 4'd7, 4'd6);    // r7 = 0x11e
      progTable[12] = memOp(condAl, 0, 4'd0, 4'd7, 12'h110);
      progTable[13] = memOp(condAl, 1, 4'd0, 4'd8, 12'h104);        // r8 = 0x5d
      progTable[14] = dpImm(condAl, fnAdd, 0, 4'd8, 4'd9, 8'h03);   // Load-use, r9 = 0x60
      progTable[15] = memOp(condAl, 0, 4'd0, 4'd9, 12'h114);
      progTable[16] = dpImm(condAl, fnSub, 1, 4'd1, 4'd10, 8'h64);  // Z=1 C=1
      progTable[17] = memOp(condEq, 0, 4'd0, 4'd1, 12'h118);
      progTable[18] = memOp(condNe, 0, 4'd0, 4'd2, 12'h11c);        // Skipped
      progTable[19] = dpImm(condAl, fnSub, 1, 4'd2, 4'd10, 8'h60);  // -3, N=1 C=0
      progTable[20] = memOp(condLt, 0, 4'd0, 4'd3, 12'h120);
      progTable[21] = memOp(condGe, 0, 4'd0, 4'd4, 12'h124);        // Skipped
      progTable[22] = memOp(condNe, 0, 4'd0, 4'd4, 12'h128);
      progTable[23] = dpImm(condAl, fnSub, 1, 4'd1, 4'd10, 8'h05);  // C=1 Z=0
      progTable[24] = memOp(condHi, 0, 4'd0, 4'd1, 12'h12c);
      progTable[25] = dpImm(condAl, fnAnd, 1, 4'd1, 4'd11, 8'h00);  // Z=1, C kept
      progTable[26] = dpImm(condCs, fnAdd, 0, 4'd0, 4'd12, 8'h77);  // Runs only if C kept
      progTable[27] = memOp(condEq, 0, 4'd0, 4'd12, 12'h130);
      progTable[28] = memOp(condHi, 0, 4'd0, 4'd12, 12'h134);       // Skipped, Z=1
      progTable[29] = branchTo(condAl, 29, 32);
      progTable[30] = memOp(condAl, 0, 4'd0, 4'd1, 12'h138);        // Flushed
      progTable[31] = memOp(condAl, 0, 4'd0, 4'd2, 12'h13c);        // Flushed
      progTable[32] = branchTo(condNe, 32, 39);                     // Not taken
      progTable[33] = memOp(condAl, 0, 4'd0, 4'd4, 12'h140);
      progTable[34] = dpImm(condAl, fnAnd, 0, 4'd0, 4'd10, 8'h00);  // Loop counter
      progTable[35] = dpImm(condAl, fnAdd, 0, 4'd10, 4'd10, 8'h01);
      progTable[36] = dpImm(condAl, fnSub, 1, 4'd10, 4'd11, 8'h05);
      progTable[37] = branchTo(condNe, 37, 35);
      progTable[38] = memOp(condAl, 0, 4'd0, 4'd10, 12'h144);
      progTable[39] = branchTo(condAl, 39, 39);                     // Park here

      expStores[0]  = {32'h100, 32'h64};
      expStores[1]  = {32'h104, 32'h5d};
      expStores[2]  = {32'h108, 32'h24};
      expStores[3]  = {32'h10c, 32'h6f};
      expStores[4]  = {32'h110, 32'h11e};
      expStores[5]  = {32'h114, 32'h60};
      expStores[6]  = {32'h118, 32'h64};
      expStores[7]  = {32'h120, 32'h24};
      expStores[8]  = {32'h128, 32'h6f};
      expStores[9]  = {32'h12c, 32'h64};
      expStores[10] = {32'h130, 32'h77};
      expStores[11] = {32'h140, 32'h6f};
      expStores[12] = {32'h144, 32'h05};

      for (int i = 0; i < 256; i++) begin
         rom[i] = (i < progLen) ? progTable[i] : '0;
         ram[i] = 32'hc0de0000 ^ (i * 4);  // Address-dependent fill
      end

      repeat (10) @(posedge clk);
      #2 reset = 1'b0;

      while (storeIdx < numStores && cycles < timeoutCycles) begin
         @(posedge clk);
         cycles++;
      end
      if (storeIdx < numStores) begin
         otherErrors++;
         $display("Timeout after %0d cycles with %0d of %0d stores seen",
                  cycles, storeIdx, numStores);
      end
      repeat (2) @(posedge clk);

      $display("Errors: %0d value mismatches, %0d other", checkErrors, otherErrors);
      if (checkErrors == 0 && otherErrors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// ==== test/armCore_asserts.sv ====
/*
  Pipeline control checks for the core, bound into armCore.
  Store strobes and branch targets are checked against the instruction
  that sat in decode two cycles earlier.
*/
`timescale 1ns/1ps

module armCore_asserts
   import armIsaPkg::*;
   import armPipePkg::*;
(
   input logic                 clk,
   input logic                 reset,
   input logic                 stallF,
   input logic                 stallD,
   input logic                 memWrite,
   input logic                 branchTakenE,
   input logic [dataWidth-1:0] pc,
   input logic [dataWidth-1:0] instrD
);

   logic                 storeD;
   logic [dataWidth-1:0] targetD;

   assign storeD = (instrD[opMsb:opLsb] == opMemory) && !instrD[lBit];
   // Word in decode was fetched at pc - 4, so R15 reads pc + 4
   assign targetD = pc + 32'd4 + (32'($signed(instrD[imm24Msb:0])) << 2);

   // Load-use holds fetch and decode for exactly one cycle
   stallHolds: assert property (@(posedge clk) disable iff (reset)
      (stallF || stallD) |=> $past(stallF == stallD) && $stable(pc) && $stable(instrD)
                            && !stallF)
      else $error("stall did not hold fetch and decode for one cycle");

   storePair: assert property (@(posedge clk) disable iff (reset)
      memWrite && $past(memWrite) |-> $past(storeD, 2) && $past(storeD, 3))
      else $error("memWrite high twice in a row without two stores behind it");

   branchLands: assert property (@(posedge clk) disable iff (reset)
      branchTakenE |=> pc == $past(targetD, 2))
      else $error("pc does not follow a taken branch target");

endmodule

// ==== verilog/alu.sv ====
/*
  Four-function ALU with one shared adder for ADD and SUB.
  C and V are only meaningful for ADD and SUB and read zero otherwise.
  C follows the ARM rule, set on no borrow for SUB.
*/
`timescale 1ns/1ps

module alu
   import armPipePkg::*;
(
   input  logic [dataWidth-1:0] a,
   input  logic [dataWidth-1:0] b,
   input  aluOpE                op,
   output logic [dataWidth-1:0] result,
   output flagsT                flags
);

   logic                 isSub, isArith;
   logic [dataWidth-1:0] bInv;
   logic [dataWidth:0]   sum;  // Carry out in top bit

   assign isSub = op == aluSub;
   assign isArith = (op == aluAdd) | isSub;
   assign bInv = isSub ? ~b : b;
   assign sum = a + bInv + isSub;

   always_comb begin
      case (op)
         aluAnd:  result = a & b;
         aluOrr:  result = a | b;
         default: result = sum[dataWidth-1:0];
      endcase
   end

   assign flags.n = result[dataWidth-1];
   assign flags.z = result == '0;
   assign flags.c = isArith & sum[dataWidth];
   // Operands of like sign after inversion, result sign differs
   assign flags.v = isArith & ~(a[dataWidth-1] ^ b[dataWidth-1] ^ isSub)
                    & (a[dataWidth-1] ^ sum[dataWidth-1]);

endmodule

// ==== verilog/armCore.sv ====
/*
  Five-stage ARMv4 subset core. Instruction and data memory must answer
  combinationally in the same cycle; there is no stall for memory.
  writeData and dataAdr are valid while memWrite is high.
*/
`timescale 1ns/1ps

module armCore
   import armPipePkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   output logic [dataWidth-1:0] pc,
   input  logic [dataWidth-1:0] instr,
   output logic                 memWrite,
   output logic [dataWidth-1:0] dataAdr,
   output logic [dataWidth-1:0] writeData,
   input  logic [dataWidth-1:0] readData
);

   logic [1:0]           regSrcD;
   immSrcE               immSrcD;
   logic                 aluSrcE;
   armPipePkg::aluOpE    aluOpE;
   logic                 branchTakenE;
   logic                 memToRegW;
   logic                 regWriteW;
   logic [dataWidth-1:0] instrD;
   flagsT                aluFlagsE;

   hazardIf hz ();

   controlUnit controlUnit_i (
      .clk, .reset, .instrD, .aluFlagsE, .regSrcD, .immSrcD, .aluSrcE,
      .aluOpE, .branchTakenE, .memWrite, .memToRegW, .regWriteW,
      .hz(hz.control)
   );

   datapath datapath_i (
      .clk, .reset, .regSrcD, .immSrcD, .aluSrcE, .aluOpE, .branchTakenE,
      .memToRegW, .regWriteW, .pc, .instr, .instrD, .aluFlagsE,
      .dataAdr, .writeData, .readData,
      .hz(hz.datapath)
   );

   hazardUnit hazardUnit_i (
      .hz(hz.hazard)
   );

endmodule

// ==== verilog/armIsaPkg.sv ====
/*
  ARMv4 subset encoding: data processing, LDR/STR and B only.
  Field positions follow the 32-bit ARM word layout. The function codes
  cover ADD, SUB, AND and ORR; other codes are not decoded.
*/
package armIsaPkg;

   localparam int regAddrWidth = 4;
   localparam logic [regAddrWidth-1:0] pcRegIndex = 4'd15; // R15 reads as PC+8

   // Instruction class, bits 27:26
   typedef enum logic [1:0] {
      opDataProc = 2'b00,
      opMemory   = 2'b01,
      opBranch   = 2'b10
   } opE;

   // Data-processing function, bits 24:21
   typedef enum logic [3:0] {
      fnAnd = 4'b0000,
      fnSub = 4'b0010,
      fnAdd = 4'b0100,
      fnOrr = 4'b1100
   } dpFunctE;

   typedef enum logic [3:0] {
      condEq = 4'b0000,
      condNe = 4'b0001,
      condCs = 4'b0010,
      condCc = 4'b0011,
      condMi = 4'b0100,
      condPl = 4'b0101,
      condVs = 4'b0110,
      condVc = 4'b0111,
      condHi = 4'b1000,
      condLs = 4'b1001,
      condGe = 4'b1010,
      condLt = 4'b1011,
      condGt = 4'b1100,
      condLe = 4'b1101,
      condAl = 4'b1110
   } condE;

   localparam int condMsb = 31, condLsb = 28;
   localparam int opMsb = 27, opLsb = 26;
   localparam int iBit = 25;                   // Immediate operand
   localparam int functMsb = 24, functLsb = 21;
   localparam int sBit = 20;                   // Set flags
   localparam int lBit = 20;                   // Load, same bit as S
   localparam int rnMsb = 19, rnLsb = 16;
   localparam int rdMsb = 15, rdLsb = 12;
   localparam int rmMsb = 3, rmLsb = 0;
   localparam int imm8Msb = 7;
   localparam int imm12Msb = 11;
   localparam int imm24Msb = 23;

endpackage

// ==== verilog/armPipePkg.sv ====
/*
  Pipeline-side types: word width, flags, ALU operations, immediate
  kinds and forwarding selects. The ALU has no carry-in and no shifter.
*/
package armPipePkg;

   localparam int dataWidth = 32;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flagsT;

   typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOrr} aluOpE;

   // 8-bit data-processing, 12-bit memory offset, 24-bit branch offset
   typedef enum logic [1:0] {imm8, imm12, branch24} immSrcE;

   typedef enum logic [1:0] {fwdNone, fwdWriteback, fwdMemory} forwardE;

   localparam logic [dataWidth-1:0] pcStep = 32'd4;
   localparam logic [dataWidth-1:0] pcReadOffset = 32'd8; // R15 view of the PC

endpackage

// ==== verilog/controlUnit.sv ====
/*
  Decode and per-stage control for ADD/SUB/AND/ORR, LDR/STR and B.
  Unknown function codes execute as ADD. Writes to R15 are suppressed.
  Condition and flag update are resolved in execute.
*/
`timescale 1ns/1ps

module controlUnit
   import armIsaPkg::*;
   import armPipePkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic [dataWidth-1:0] instrD,
   input  flagsT                aluFlagsE,
   output logic [1:0]           regSrcD,   // [0] Rn is R15, [1] Rm field is Rd
   output immSrcE               immSrcD,
   output logic                 aluSrcE,
   output armPipePkg::aluOpE    aluOpE,
   output logic                 branchTakenE,
   output logic                 memWrite,
   output logic                 memToRegW,
   output logic                 regWriteW,
   hazardIf.control             hz
);

   opE                opD;
   dpFunctE           functD;
   armPipePkg::aluOpE aluOpD;
   logic              aluSrcD, memToRegD, regWriteD, memWriteD, branchD;
   logic [1:0]        flagWriteD;  // {nz, cv}
   logic              memToRegE, regWriteE, memWriteE, branchE;
   logic [1:0]        flagWriteE;
   condE              condCodeE;
   logic              condEx;
   flagsT             flagsQ, flagsNext;
   logic              regWriteM, memToRegM;

   assign opD = opE'(instrD[opMsb:opLsb]);
   assign functD = dpFunctE'(instrD[functMsb:functLsb]);

   always_comb begin
      regSrcD = 2'b00;
      immSrcD = imm8;
      aluSrcD = 1'b0;
      memToRegD = 1'b0;
      regWriteD = 1'b0;
      memWriteD = 1'b0;
      branchD = 1'b0;
      aluOpD = aluAdd;  // Address and branch target arithmetic
      flagWriteD = 2'b00;
      case (opD)
         opDataProc: begin
            aluSrcD = instrD[iBit];
            regWriteD = instrD[rdMsb:rdLsb] != pcRegIndex;
            case (functD)
               fnAnd:   aluOpD = aluAnd;
               fnSub:   aluOpD = aluSub;
               fnOrr:   aluOpD = aluOrr;
               default: aluOpD = aluAdd;
            endcase
            flagWriteD[1] = instrD[sBit];
            flagWriteD[0] = instrD[sBit] & (aluOpD == aluAdd || aluOpD == aluSub);
         end
         opMemory: begin
            immSrcD = imm12;
            aluSrcD = 1'b1;
            if (instrD[lBit]) begin
               memToRegD = 1'b1;
               regWriteD = instrD[rdMsb:rdLsb] != pcRegIndex;
            end else begin
               regSrcD = 2'b10;  // Store data comes from Rd
               memWriteD = 1'b1;
            end
         end
         opBranch: begin
            regSrcD = 2'b01;
            immSrcD = branch24;
            aluSrcD = 1'b1;
            branchD = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         aluSrcE <= 1'b0;
         aluOpE <= aluAdd;
         condCodeE <= condEq;
         {memToRegE, regWriteE, memWriteE, branchE, flagWriteE} <= '0;
      end else begin
         aluSrcE <= aluSrcD;
         aluOpE <= aluOpD;
         condCodeE <= condE'(instrD[condMsb:condLsb]);
         if (hz.flushE)
            {memToRegE, regWriteE, memWriteE, branchE, flagWriteE} <= '0; // Bubble
         else
            {memToRegE, regWriteE, memWriteE, branchE, flagWriteE} <=
               {memToRegD, regWriteD, memWriteD, branchD, flagWriteD};
      end
   end

   always_comb begin
      case (condCodeE)
         condEq:  condEx = flagsQ.z;
         condNe:  condEx = ~flagsQ.z;
         condCs:  condEx = flagsQ.c;
         condCc:  condEx = ~flagsQ.c;
         condMi:  condEx = flagsQ.n;
         condPl:  condEx = ~flagsQ.n;
         condVs:  condEx = flagsQ.v;
         condVc:  condEx = ~flagsQ.v;
         condHi:  condEx = flagsQ.c & ~flagsQ.z;
         condLs:  condEx = ~flagsQ.c | flagsQ.z;
         condGe:  condEx = flagsQ.n == flagsQ.v;
         condLt:  condEx = flagsQ.n != flagsQ.v;
         condGt:  condEx = ~flagsQ.z & (flagsQ.n == flagsQ.v);
         condLe:  condEx = flagsQ.z | (flagsQ.n != flagsQ.v);
         condAl:  condEx = 1'b1;
         default: condEx = 1'b0;  // 1111 space treated as no-op
      endcase
   end

   // AND/ORR leave C and V alone
   always_comb begin
      flagsNext = flagsQ;
      if (flagWriteE[1] & condEx) begin
         flagsNext.n = aluFlagsE.n;
         flagsNext.z = aluFlagsE.z;
      end
      if (flagWriteE[0] & condEx) begin
         flagsNext.c = aluFlagsE.c;
         flagsNext.v = aluFlagsE.v;
      end
   end

   assign branchTakenE = branchE & condEx;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flagsQ <= '0;
         {regWriteM, memToRegM, memWrite} <= '0;
         {regWriteW, memToRegW} <= '0;
      end else begin
         flagsQ <= flagsNext;
         regWriteM <= regWriteE & condEx;
         memToRegM <= memToRegE;
         memWrite <= memWriteE & condEx;
         regWriteW <= regWriteM;
         memToRegW <= memToRegM;
      end
   end

   assign hz.regWriteM = regWriteM;
   assign hz.regWriteW = regWriteW;
   assign hz.memToRegE = memToRegE;
   assign hz.branchTakenE = branchTakenE;

endmodule

// ==== verilog/datapath.sv ====
/*
  PC, register file, operand forwarding and data pipeline registers.
  The register file has no reset and writes on the falling edge, so
  decode sees a writeback result in the same cycle. No shifter.
*/
`timescale 1ns/1ps

module datapath
   import armIsaPkg::*;
   import armPipePkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic [1:0]           regSrcD,
   input  immSrcE               immSrcD,
   input  logic                 aluSrcE,
   input  armPipePkg::aluOpE    aluOpE,
   input  logic                 branchTakenE,
   input  logic                 memToRegW,
   input  logic                 regWriteW,
   output logic [dataWidth-1:0] pc,
   input  logic [dataWidth-1:0] instr,
   output logic [dataWidth-1:0] instrD,
   output flagsT                aluFlagsE,
   output logic [dataWidth-1:0] dataAdr,
   output logic [dataWidth-1:0] writeData,
   input  logic [dataWidth-1:0] readData,
   hazardIf.datapath            hz
);

   logic [dataWidth-1:0]    pcPlus4F, r15D, rd1D, rd2D, extImmD;
   logic [regAddrWidth-1:0] ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W;
   logic [dataWidth-1:0]    rd1E, rd2E, extImmE, srcAE, srcBE, writeDataE, aluResultE;
   logic [dataWidth-1:0]    aluOutM, writeDataM, aluOutW, readDataW, resultW;
   logic [dataWidth-1:0]    regs [0:14];

   assign pcPlus4F = pc + pcStep;
   assign r15D = pc + (pcReadOffset - pcStep); // Decode runs one word behind fetch

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pc <= '0;
         instrD <= '0;
      end else begin
         if (!hz.stallF)
            pc <= branchTakenE ? aluResultE : pcPlus4F;
         if (hz.flushD)
            instrD <= '0;
         else if (!hz.stallD)
            instrD <= instr;
      end
   end

   assign ra1D = regSrcD[0] ? pcRegIndex : instrD[rnMsb:rnLsb];
   assign ra2D = regSrcD[1] ? instrD[rdMsb:rdLsb] : instrD[rmMsb:rmLsb];

   always_ff @(negedge clk) begin
      if (regWriteW)
         regs[wa3W] <= resultW;  // R15 writes already blocked in control
   end

   assign rd1D = (ra1D == pcRegIndex) ? r15D : regs[ra1D];
   assign rd2D = (ra2D == pcRegIndex) ? r15D : regs[ra2D];

   always_comb begin
      case (immSrcD)
         imm8:     extImmD = {{(dataWidth-8){1'b0}}, instrD[imm8Msb:0]};
         imm12:    extImmD = {{(dataWidth-12){1'b0}}, instrD[imm12Msb:0]};
         branch24: extImmD = {{(dataWidth-26){instrD[imm24Msb]}}, instrD[imm24Msb:0], 2'b00};
         default:  extImmD = '0;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         {rd1E, rd2E, extImmE} <= '0;
         {ra1E, ra2E, wa3E} <= '0;
         {aluOutM, writeDataM, wa3M} <= '0;
         {aluOutW, readDataW, wa3W} <= '0;
      end else begin
         {rd1E, rd2E, extImmE} <= {rd1D, rd2D, extImmD};
         {ra1E, ra2E, wa3E} <= {ra1D, ra2D, instrD[rdMsb:rdLsb]};
         {aluOutM, writeDataM, wa3M} <= {aluResultE, writeDataE, wa3E};
         {aluOutW, readDataW, wa3W} <= {aluOutM, readData, wa3M};
      end
   end

   // Memory stage wins over writeback
   always_comb begin
      case (hz.forwardA)
         fwdMemory:    srcAE = aluOutM;
         fwdWriteback: srcAE = resultW;
         default:      srcAE = rd1E;
      endcase
      case (hz.forwardB)
         fwdMemory:    writeDataE = aluOutM;
         fwdWriteback: writeDataE = resultW;
         default:      writeDataE = rd2E;
      endcase
   end

   assign srcBE = aluSrcE ? extImmE : writeDataE;

   alu alu_i (.a(srcAE), .b(srcBE), .op(aluOpE), .result(aluResultE), .flags(aluFlagsE));

   assign resultW = memToRegW ? readDataW : aluOutW;
   assign dataAdr = aluOutM;
   assign writeData = writeDataM;

   assign hz.match1EM = ra1E == wa3M;
   assign hz.match1EW = ra1E == wa3W;
   assign hz.match2EM = ra2E == wa3M;
   assign hz.match2EW = ra2E == wa3W;
   assign hz.match12DE = (ra1D == wa3E) | (ra2D == wa3E);

endmodule

// ==== verilog/hazardIf.sv ====
/*
  Hazard signals shared by the datapath, the control unit and the
  hazard unit. Match flags are raw address compares; qualifying them
  with register writes is left to the hazard unit.
*/
`timescale 1ns/1ps

interface hazardIf import armPipePkg::*; ();

   logic match1EM, match1EW;  // Execute Rn vs memory/writeback Rd
   logic match2EM, match2EW;  // Execute Rm vs memory/writeback Rd
   logic match12DE;           // Decode sources vs execute Rd
   logic regWriteM, regWriteW;
   logic memToRegE;
   logic branchTakenE;
   forwardE forwardA, forwardB;
   logic stallF, stallD;
   logic flushD, flushE;

   modport datapath (output match1EM, match1EW, match2EM, match2EW, match12DE,
                     input forwardA, forwardB, stallF, stallD, flushD);

   modport control (output regWriteM, regWriteW, memToRegE, branchTakenE,
                    input flushE);

   modport hazard (input match1EM, match1EW, match2EM, match2EW, match12DE,
                   input regWriteM, regWriteW, memToRegE, branchTakenE,
                   output forwardA, forwardB, stallF, stallD, flushD, flushE);

   modport monitor (input match1EM, match1EW, match2EM, match2EW, match12DE,
                    input regWriteM, regWriteW, memToRegE, branchTakenE,
                    input forwardA, forwardB, stallF, stallD, flushD, flushE);

endinterface

// ==== verilog/hazardUnit.sv ====
/*
  Forwarding, load-use stall and branch flush for the five-stage core.
  A load-use hazard costs one bubble; a taken branch flushes decode and
  execute. Address matches may be conservative for immediate forms.
*/
`timescale 1ns/1ps

module hazardUnit
   import armPipePkg::*;
(
   hazardIf.hazard hz
);

   logic loadUseStall;

   always_comb begin
      if (hz.match1EM & hz.regWriteM)
         hz.forwardA = fwdMemory;
      else if (hz.match1EW & hz.regWriteW)
         hz.forwardA = fwdWriteback;
      else
         hz.forwardA = fwdNone;

      if (hz.match2EM & hz.regWriteM)
         hz.forwardB = fwdMemory;
      else if (hz.match2EW & hz.regWriteW)
         hz.forwardB = fwdWriteback;
      else
         hz.forwardB = fwdNone;
   end

   // LDR in execute feeding the instruction in decode
   assign loadUseStall = hz.match12DE & hz.memToRegE;

   assign hz.stallF = loadUseStall;
   assign hz.stallD = loadUseStall;
   assign hz.flushE = loadUseStall | hz.branchTakenE;
   assign hz.flushD = hz.branchTakenE;  // Both younger instrs dropped

endmodule
